// ==== include/sched_config.svh ====
`ifndef SCHED_CONFIG_SVH
`define SCHED_CONFIG_SVH

// rank geometry, one rank of 2 bank groups x 4 banks
`define SCHED_ROW_BITS 8
`define SCHED_COL_BITS 4
`define SCHED_BG_BITS 1
`define SCHED_BA_BITS 2
`define SCHED_BANKS 8

// request payload width
`define SCHED_DATA_BITS 32

// entries held per bank before busy is raised
`define SCHED_QUEUE_DEPTH 4

// bank recovery times in clock cycles
`define SCHED_ACT_LATENCY 8
`define SCHED_PRE_LATENCY 5

`endif

// ==== rtl/dram_geom_pkg.sv ====
`default_nettype none

`include "sched_config.svh"

package dram_geom_pkg;

    typedef logic [`SCHED_ROW_BITS-1:0] row_t;
    typedef logic [`SCHED_COL_BITS-1:0] col_t;
    typedef logic [`SCHED_BG_BITS-1:0]  bg_t;
    typedef logic [`SCHED_BA_BITS-1:0]  ba_t;

    // bank group in the upper bit, bank below it
    typedef logic [`SCHED_BG_BITS+`SCHED_BA_BITS-1:0] bank_idx_t;

    // flat request address, msb first
    typedef struct packed {
        bg_t  bg;
        ba_t  ba;
        row_t row;
        col_t col;
    } mem_addr_t;

    // address word as seen with ACTIVATE
    typedef struct packed {
        bg_t  bg;
        ba_t  ba;
        row_t row;
    } cmd_row_view_t;

    // address word as seen with READ, WRITE and PRECHARGE
    typedef struct packed {
        bg_t                                     bg;
        ba_t                                     ba;
        logic [`SCHED_ROW_BITS-`SCHED_COL_BITS-1:0] pad; // always zero
        col_t                                    col;
    } cmd_col_view_t;

    typedef union packed {
        cmd_row_view_t row_view;
        cmd_col_view_t col_view;
    } cmd_addr_u;

endpackage

`default_nettype wire

// ==== rtl/sched_cmd_pkg.sv ====
`default_nettype none

`include "sched_config.svh"

package sched_cmd_pkg;

    import dram_geom_pkg::*;

    typedef logic [`SCHED_DATA_BITS-1:0] data_t;

    // encoding matches the controller side
    typedef enum logic [1:0] {
        CMD_READ      = 2'd0,
        CMD_WRITE     = 2'd1,
        CMD_ACTIVATE  = 2'd2,
        CMD_PRECHARGE = 2'd3
    } sched_cmd_e;

    // request after address decode, as held in the bank FIFOs
    typedef struct packed {
        bg_t   bg;
        ba_t   ba;
        row_t  row;
        col_t  col;
        logic  write; // 1 for write, 0 for read
        data_t data;
    } mem_request_t;

endpackage

`default_nettype wire

// ==== rtl/request_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "sched_config.svh"

module request_decoder
    import dram_geom_pkg::*;
    import sched_cmd_pkg::*;
(
    input  logic                     clk_in,
    input  logic                     rst_in,
    input  logic                     valid_in,
    input  mem_addr_t                addr_in,
    input  logic                     write_in,
    input  data_t                    data_in,
    output mem_request_t             req,
    output logic [`SCHED_BANKS-1:0]  push
);

    bank_idx_t bank;

    assign bank = {addr_in.bg, addr_in.ba};

    // one push pulse per strobe, toward the addressed bank only
    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            push <= '0;
        end else if (valid_in) begin
            push <= `SCHED_BANKS'(1) << bank;
        end else begin
            push <= '0;
        end
    end

    // field split of the flat address
    always_ff @(posedge clk_in) begin
        if (valid_in) begin
            req.bg    <= addr_in.bg;
            req.ba    <= addr_in.ba;
            req.row   <= addr_in.row;
            req.col   <= addr_in.col;
            req.write <= write_in;
            req.data  <= data_in;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/bank_queue.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "sched_config.svh"

module bank_queue
    import sched_cmd_pkg::*;
(
    input  logic         clk_in,
    input  logic         rst_in,
    input  logic         push,
    input  mem_request_t req,
    input  logic         pop,
    output mem_request_t head,
    output logic         empty,
    output logic         full
);

    localparam int DEPTH    = `SCHED_QUEUE_DEPTH;
    localparam int PTR_BITS = $clog2(DEPTH);

    mem_request_t          mem [DEPTH];
    logic [PTR_BITS-1:0]   rd_ptr;
    logic [PTR_BITS-1:0]   wr_ptr;
    logic [PTR_BITS:0]     count;
    logic [PTR_BITS:0]     count_next;
    logic                  do_push;
    logic                  do_pop;

    // a push into a full queue is only taken when a pop frees a slot
    assign do_push = push && (!full || pop);
    assign do_pop  = pop && !empty;

    assign head = mem[rd_ptr];

    always_comb begin
        count_next = count;
        case ({do_push, do_pop})
            2'b10:   count_next = count + 1'b1;
            2'b01:   count_next = count - 1'b1;
            default: count_next = count; // both or neither
        endcase
    end

    always_ff @(posedge clk_in) begin
        if (do_push) begin
            mem[wr_ptr] <= req;
        end
    end

    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
            empty  <= 1'b1;
            full   <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count_next;
            empty <= (count_next == '0);
            full  <= (count_next == (PTR_BITS + 1)'(DEPTH));
        end
    end

endmodule

`default_nettype wire

// ==== rtl/bank_timer.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "sched_config.svh"

module bank_timer
    import dram_geom_pkg::*;
(
    input  logic                           clk_in,
    input  logic                           rst_in,
    input  logic                           act_strobe,
    input  logic                           pre_strobe,
    input  bank_idx_t                      strobe_bank,
    input  row_t                           strobe_row,
    output row_t [`SCHED_BANKS-1:0]        open_rows,
    output logic [`SCHED_BANKS-1:0]        row_valid,
    output logic [`SCHED_BANKS-1:0]        bank_busy
);

    localparam int ACT_LAT  = `SCHED_ACT_LATENCY;
    localparam int PRE_LAT  = `SCHED_PRE_LATENCY;
    localparam int MAX_LAT  = (ACT_LAT > PRE_LAT) ? ACT_LAT : PRE_LAT;
    localparam int CNT_BITS = $clog2(MAX_LAT + 1);

    logic [CNT_BITS-1:0] busy_cnt [`SCHED_BANKS];

    // the row register only matters while row_valid is set
    always_ff @(posedge clk_in) begin
        if (act_strobe) begin
            open_rows[strobe_bank] <= strobe_row;
        end
    end

    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            row_valid <= '0;
            for (int b = 0; b < `SCHED_BANKS; b++) begin
                busy_cnt[b] <= '0;
            end
        end else begin
            for (int b = 0; b < `SCHED_BANKS; b++) begin
                if (act_strobe && strobe_bank == bank_idx_t'(b)) begin
                    row_valid[b] <= 1'b1;
                    busy_cnt[b]  <= CNT_BITS'(ACT_LAT);
                end else if (pre_strobe && strobe_bank == bank_idx_t'(b)) begin
                    row_valid[b] <= 1'b0; // bank closed
                    busy_cnt[b]  <= CNT_BITS'(PRE_LAT);
                end else if (busy_cnt[b] != '0) begin
                    busy_cnt[b] <= busy_cnt[b] - 1'b1;
                end
            end
        end
    end

    always_comb begin
        for (int b = 0; b < `SCHED_BANKS; b++) begin
            bank_busy[b] = (busy_cnt[b] != '0);
        end
    end

endmodule

`default_nettype wire

// ==== rtl/cmd_issue.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "sched_config.svh"

module cmd_issue
    import dram_geom_pkg::*;
    import sched_cmd_pkg::*;
(
    input  logic                              clk_in,
    input  logic                              rst_in,
    input  logic                              cmd_ready,
    input  mem_request_t [`SCHED_BANKS-1:0]   heads,
    input  logic [`SCHED_BANKS-1:0]           empties,
    input  row_t [`SCHED_BANKS-1:0]           open_rows,
    input  logic [`SCHED_BANKS-1:0]           row_valid,
    input  logic [`SCHED_BANKS-1:0]           bank_busy,
    output logic [`SCHED_BANKS-1:0]           pop,
    output logic                              act_strobe,
    output logic                              pre_strobe,
    output bank_idx_t                         strobe_bank,
    output row_t                              strobe_row,
    output logic                              valid_out,
    output sched_cmd_e                        cmd_out,
    output cmd_addr_u                         cmd_addr_out,
    output data_t                             data_out
);

    logic         found;
    bank_idx_t    sel;
    mem_request_t sel_req;
    logic         row_hit;
    logic         fire;
    sched_cmd_e   next_cmd;
    cmd_addr_u    next_addr;
    data_t        next_data;

    // lowest index bank with work and no recovery pending
    always_comb begin
        found = 1'b0;
        sel   = '0;
        for (int b = 0; b < `SCHED_BANKS; b++) begin
            if (!found && !empties[b] && !bank_busy[b]) begin
                found = 1'b1;
                sel   = bank_idx_t'(b);
            end
        end
    end

    assign sel_req = heads[sel];
    assign row_hit = row_valid[sel] && (open_rows[sel] == sel_req.row);
    assign fire    = cmd_ready && found;

    always_comb begin
        next_addr = '0;
        next_data = '0;
        if (!row_valid[sel]) begin
            next_cmd                = CMD_ACTIVATE; // closed bank
            next_addr.row_view.bg   = sel_req.bg;
            next_addr.row_view.ba   = sel_req.ba;
            next_addr.row_view.row  = sel_req.row;
        end else begin
            next_addr.col_view.bg  = sel_req.bg;
            next_addr.col_view.ba  = sel_req.ba;
            next_addr.col_view.col = sel_req.col;
            if (row_hit) begin
                next_cmd = sel_req.write ? CMD_WRITE : CMD_READ;
                if (sel_req.write) begin
                    next_data = sel_req.data;
                end
            end else begin
                next_cmd = CMD_PRECHARGE; // wrong row open
            end
        end
    end

    // strobes and pop act on the same edge the command is registered
    assign act_strobe  = fire && (next_cmd == CMD_ACTIVATE);
    assign pre_strobe  = fire && (next_cmd == CMD_PRECHARGE);
    assign strobe_bank = sel;
    assign strobe_row  = sel_req.row;
    assign pop         = (fire && row_hit) ? (`SCHED_BANKS'(1) << sel) : '0;

    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            valid_out <= 1'b0;
        end else begin
            valid_out <= fire;
        end
    end

    // command word holds between commands
    always_ff @(posedge clk_in) begin
        if (fire) begin
            cmd_out      <= next_cmd;
            cmd_addr_out <= next_addr;
            data_out     <= next_data;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/request_scheduler.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "sched_config.svh"

module request_scheduler
    import dram_geom_pkg::*;
    import sched_cmd_pkg::*;
(
    input  logic       clk_in,
    input  logic       rst_in,
    input  logic       valid_in,
    input  mem_addr_t  addr_in,
    input  logic       write_in,
    input  data_t      data_in,
    input  logic       cmd_ready,
    output logic       busy,
    output logic       valid_out,
    output sched_cmd_e cmd_out,
    output cmd_addr_u  cmd_addr_out,
    output data_t      data_out
);

    mem_request_t                     req;
    logic [`SCHED_BANKS-1:0]          push;
    logic [`SCHED_BANKS-1:0]          pop;
    mem_request_t [`SCHED_BANKS-1:0]  heads;
    logic [`SCHED_BANKS-1:0]          empties;
    logic [`SCHED_BANKS-1:0]          fulls;
    logic                             act_strobe;
    logic                             pre_strobe;
    bank_idx_t                        strobe_bank;
    row_t                             strobe_row;
    row_t [`SCHED_BANKS-1:0]          open_rows;
    logic [`SCHED_BANKS-1:0]          row_valid;
    logic [`SCHED_BANKS-1:0]          bank_busy;

    // source must hold off while any bank FIFO is full
    assign busy = |fulls;

    request_decoder u_decoder (
        .clk_in   (clk_in),
        .rst_in   (rst_in),
        .valid_in (valid_in),
        .addr_in  (addr_in),
        .write_in (write_in),
        .data_in  (data_in),
        .req      (req),
        .push     (push)
    );

    for (genvar b = 0; b < `SCHED_BANKS; b++) begin : g_bank
        bank_queue u_queue (
            .clk_in (clk_in),
            .rst_in (rst_in),
            .push   (push[b]),
            .req    (req),
            .pop    (pop[b]),
            .head   (heads[b]),
            .empty  (empties[b]),
            .full   (fulls[b])
        );
    end

    bank_timer u_timer (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .act_strobe  (act_strobe),
        .pre_strobe  (pre_strobe),
        .strobe_bank (strobe_bank),
        .strobe_row  (strobe_row),
        .open_rows   (open_rows),
        .row_valid   (row_valid),
        .bank_busy   (bank_busy)
    );

    cmd_issue u_issue (
        .clk_in       (clk_in),
        .rst_in       (rst_in),
        .cmd_ready    (cmd_ready),
        .heads        (heads),
        .empties      (empties),
        .open_rows    (open_rows),
        .row_valid    (row_valid),
        .bank_busy    (bank_busy),
        .pop          (pop),
        .act_strobe   (act_strobe),
        .pre_strobe   (pre_strobe),
        .strobe_bank  (strobe_bank),
        .strobe_row   (strobe_row),
        .valid_out    (valid_out),
        .cmd_out      (cmd_out),
        .cmd_addr_out (cmd_addr_out),
        .data_out     (data_out)
    );

endmodule

`default_nettype wire

// ==== tests/tb_request_scheduler.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "sched_config.svh"

module tb_request_scheduler
    import dram_geom_pkg::*;
    import sched_cmd_pkg::*;
();

    localparam int CLK_HALF        = 5;
    localparam int N_DIRECTED      = 6;
    localparam int N_TESTS         = 26;
    localparam int WATCHDOG_CYCLES =
        N_TESTS * (`SCHED_ACT_LATENCY + `SCHED_PRE_LATENCY + 20);

    typedef struct {
        mem_addr_t addr;
        logic      write;
        data_t     data;
        int        stall; // cycles of cmd_ready low after the strobe
        string     name;
    } stim_t;

    logic       clk_in = 1'b0;
    logic       rst_in;
    logic       valid_in;
    mem_addr_t  addr_in;
    logic       write_in;
    data_t      data_in;
    logic       cmd_ready;
    logic       busy;
    logic       valid_out;
    sched_cmd_e cmd_out;
    cmd_addr_u  cmd_addr_out;
    data_t      data_out;

    stim_t       stim [N_TESTS];
    logic [31:0] lcg_state = 32'h51ca395f;

    // reference model, one open row per bank
    logic [`SCHED_BANKS-1:0] model_open = '0;
    row_t                    model_row [`SCHED_BANKS];

    sched_cmd_e exp_cmd  [$];
    cmd_addr_u  exp_addr [$];
    data_t      exp_data [$];

    request_scheduler uut (
        .clk_in       (clk_in),
        .rst_in       (rst_in),
        .valid_in     (valid_in),
        .addr_in      (addr_in),
        .write_in     (write_in),
        .data_in      (data_in),
        .cmd_ready    (cmd_ready),
        .busy         (busy),
        .valid_out    (valid_out),
        .cmd_out      (cmd_out),
        .cmd_addr_out (cmd_addr_out),
        .data_out     (data_out)
    );

    always #CLK_HALF clk_in = ~clk_in;

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // ACTIVATE carries the row view
    function automatic cmd_addr_u row_word(mem_addr_t a);
        cmd_addr_u w;
        w = '0;
        w.row_view.bg  = a.bg;
        w.row_view.ba  = a.ba;
        w.row_view.row = a.row;
        return w;
    endfunction

    // everything else carries the column view, pad bits zero
    function automatic cmd_addr_u col_word(mem_addr_t a);
        cmd_addr_u w;
        w = '0;
        w.col_view.bg  = a.bg;
        w.col_view.ba  = a.ba;
        w.col_view.col = a.col;
        return w;
    endfunction

    task automatic fail_run();
        $display("Errors found");
        $fatal(1, "stopping at the first mismatch");
    endtask

    task automatic check_cmd(string name, sched_cmd_e expected, sched_cmd_e actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected %s, actual %s", name, expected.name(), actual.name());
            fail_run();
        end
    endtask

    task automatic check_addr(string name, cmd_addr_u expected, cmd_addr_u actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected addr %h, actual addr %h", name, expected, actual);
            fail_run();
        end
    endtask

    task automatic check_data(string name, data_t expected, data_t actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected data %h, actual data %h", name, expected, actual);
            fail_run();
        end
    endtask

    task automatic check_flag(string name, logic expected, logic actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected %b, actual %b", name, expected, actual);
            fail_run();
        end
    endtask

    task automatic load_entry(int idx, bg_t bg, ba_t ba, row_t row, col_t col,
                              logic write, data_t data, int stall, string name);
        stim[idx].addr  = {bg, ba, row, col};
        stim[idx].write = write;
        stim[idx].data  = data;
        stim[idx].stall = stall;
        stim[idx].name  = name;
    endtask

    // closed bank -> ACT, hit -> access, miss -> PRE ACT access
    task automatic expect_commands(int idx);
        bank_idx_t b;
        b = {stim[idx].addr.bg, stim[idx].addr.ba};
        if (model_open[b] && model_row[b] != stim[idx].addr.row) begin
            exp_cmd.push_back(CMD_PRECHARGE);
            exp_addr.push_back(col_word(stim[idx].addr));
            exp_data.push_back('0);
            model_open[b] = 1'b0;
        end
        if (!model_open[b]) begin
            exp_cmd.push_back(CMD_ACTIVATE);
            exp_addr.push_back(row_word(stim[idx].addr));
            exp_data.push_back('0);
            model_open[b] = 1'b1;
            model_row[b]  = stim[idx].addr.row;
        end
        exp_cmd.push_back(stim[idx].write ? CMD_WRITE : CMD_READ);
        exp_addr.push_back(col_word(stim[idx].addr));
        exp_data.push_back(stim[idx].write ? stim[idx].data : '0);
    endtask

    task automatic apply_entry(int idx);
        @(negedge clk_in);
        valid_in  = 1'b1;
        addr_in   = stim[idx].addr;
        write_in  = stim[idx].write;
        data_in   = stim[idx].data;
        cmd_ready = (stim[idx].stall == 0);
        @(negedge clk_in);
        valid_in = 1'b0;
        for (int k = 0; k < stim[idx].stall; k++) begin
            check_flag($sformatf("%s stall", stim[idx].name), 1'b0, valid_out);
            @(negedge clk_in);
        end
        cmd_ready = 1'b1;
        while (exp_cmd.size() > 0) begin
            @(negedge clk_in);
            if (valid_out) begin
                check_cmd(stim[idx].name, exp_cmd[0], cmd_out);
                check_addr(stim[idx].name, exp_addr[0], cmd_addr_out);
                check_data(stim[idx].name, exp_data[0], data_out);
                void'(exp_cmd.pop_front());
                void'(exp_addr.pop_front());
                void'(exp_data.pop_front());
            end
        end
    endtask

    initial begin
        #(WATCHDOG_CYCLES * 2 * CLK_HALF);
        $display("timeout: the scheduler did not finish all requests in time");
        $display("Errors found");
        $fatal(1, "watchdog expired");
    end

    initial begin
        logic [31:0] r;
        rst_in    = 1'b1;
        valid_in  = 1'b0;
        addr_in   = '0;
        write_in  = 1'b0;
        data_in   = '0;
        cmd_ready = 1'b1;

        load_entry(0, 1'b0, 2'd0, 8'h12, 4'h3, 1'b0, 32'hdeadbeef, 0, "read_closed");
        load_entry(1, 1'b0, 2'd0, 8'h12, 4'h5, 1'b1, 32'hcafe0001, 0, "write_hit");
        load_entry(2, 1'b0, 2'd0, 8'h34, 4'h7, 1'b0, 32'h00000000, 0, "read_miss");
        load_entry(3, 1'b1, 2'd1, 8'h56, 4'h9, 1'b1, 32'h12345678, 6, "write_stall");
        load_entry(4, 1'b1, 2'd1, 8'h57, 4'h1, 1'b0, 32'h0badf00d, 4, "miss_stall");
        load_entry(5, 1'b0, 2'd2, 8'h12, 4'hf, 1'b1, 32'ha5a5a5a5, 0, "write_bank2");
        for (int i = N_DIRECTED; i < N_TESTS; i++) begin
            r = next_random();
            // few rows per bank so hits and misses both show up
            load_entry(i, r[31], r[30:29], {6'd0, r[28:27]}, r[3:0], r[16],
                       next_random(), int'(r[9:8]), $sformatf("random_%0d", i));
        end

        repeat (4) @(negedge clk_in);
        rst_in = 1'b0;

        repeat (8) begin
            @(negedge clk_in);
            check_flag("idle valid_out", 1'b0, valid_out);
            check_flag("idle busy", 1'b0, busy);
        end

        for (int i = 0; i < N_TESTS; i++) begin
            expect_commands(i);
            apply_entry(i);
        end

        // no stray command once every request is done
        repeat (2) begin
            @(negedge clk_in);
            check_flag("final idle valid_out", 1'b0, valid_out);
        end
        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+include
rtl/dram_geom_pkg.sv
rtl/sched_cmd_pkg.sv
rtl/request_decoder.sv
rtl/bank_queue.sv
rtl/bank_timer.sv
rtl/cmd_issue.sv
rtl/request_scheduler.sv
tests/tb_request_scheduler.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with Verilator, run, then judge the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_request_scheduler \
    -f sources.f -o tb_sim || { echo "build failed"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
cat sim.log
grep -q "Errors found" sim.log && { echo "simulation failed"; exit 1; }
grep -q "No errors" sim.log || { echo "simulation did not complete"; exit 1; }
echo "simulation passed"
